/* hw/board_cfg.svh */
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// AXI slave port
`define BOARD_ID_W 4
`define BOARD_ADDR_W 28
`define BOARD_DATA_W 32

// On-chip store standing in for the DDR3 part
`define BOARD_MEM_WORDS 1024

// Clocks spent in calibration before the system leaves reset
`define BOARD_CALIB_CYCLES 40

`define BOARD_NUM_UART 1

`endif

/* hw/board_pkg.sv */
`include "board_cfg.svh"

package board_pkg;

   typedef logic [`BOARD_ID_W-1:0]             axi_id_t;
   typedef logic [`BOARD_ADDR_W-1:0]           axi_addr_t;
   typedef logic [`BOARD_DATA_W-1:0]           axi_data_t;
   typedef logic [`BOARD_DATA_W/8-1:0]         axi_strb_t;
   typedef logic [7:0]                         axi_len_t;   // Beats minus one
   typedef logic [1:0]                         axi_burst_t; // 0 FIXED, else INCR
   typedef logic [1:0]                         axi_resp_t;
   typedef logic [$clog2(`BOARD_MEM_WORDS)-1:0] word_addr_t;

   localparam axi_resp_t resp_okay   = 2'b00;
   localparam axi_resp_t resp_decerr = 2'b11;

   // Board bring-up sequence
   typedef enum logic [1:0] {
      in_reset,
      calibrating,
      releasing,
      running
   } seq_state_t;

endpackage

/* hw/mem_req_if.sv */
`timescale 1ns/1ns
`include "board_cfg.svh"

// Word store port, no handshake. The store always accepts
interface mem_req_if;

   logic                   wr_en;
   board_pkg::word_addr_t  wr_addr;
   board_pkg::axi_data_t   wdata;
   board_pkg::axi_strb_t   wstrb;

   logic                   rd_en;
   board_pkg::word_addr_t  rd_addr;
   board_pkg::axi_data_t   rdata;   // Valid the cycle after rd_en, held until next read

   modport master (output wr_en, wr_addr, wdata, wstrb, rd_en, rd_addr,
                   input  rdata);

   modport store  (input  wr_en, wr_addr, wdata, wstrb, rd_en, rd_addr,
                   output rdata);

endinterface

/* hw/calib_timer.sv */
`timescale 1ns/1ns
`include "board_cfg.svh"

module calib_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   output logic done
);

   localparam int cnt_w = $clog2(`BOARD_CALIB_CYCLES + 1);

   logic [cnt_w-1:0] cnt;

   // The start edge counts as the first clock of the window
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt  <= '0;
         done <= 1'b0;
      end else if (start) begin
         cnt  <= cnt_w'(`BOARD_CALIB_CYCLES - 1);
         done <= 1'b0;
      end else if (cnt != '0) begin
         cnt  <= cnt - 1'b1;
         done <= (cnt == cnt_w'(1)); // Sticks once set
      end
   end

   // Sequencer must not restart a running window
   a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> cnt == '0);

endmodule

/* hw/reset_seq.sv */
`timescale 1ns/1ns
`include "board_cfg.svh"

module reset_seq (
   input  logic clk,
   input  logic rst_n,
   input  logic timer_done,
   output logic timer_start,
   output logic sys_rst,
   output logic calib_done,
   output logic bus_en
);

   board_pkg::seq_state_t state;
   board_pkg::seq_state_t state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         board_pkg::in_reset:    state_nxt = board_pkg::calibrating;
         board_pkg::calibrating: begin
            if (timer_done)
               state_nxt = board_pkg::releasing;
         end
         board_pkg::releasing:   state_nxt = board_pkg::running;
         default:                state_nxt = board_pkg::running;
      endcase
   end

   // Pulses on the first edge with rst_n high
   assign timer_start = (state == board_pkg::in_reset);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= board_pkg::in_reset;
         sys_rst    <= 1'b1;
         calib_done <= 1'b0;
         bus_en     <= 1'b0;
      end else begin
         state      <= state_nxt;
         sys_rst    <= (state_nxt != board_pkg::running);
         calib_done <= (state_nxt == board_pkg::releasing) ||
                       (state_nxt == board_pkg::running);
         bus_en     <= (state_nxt == board_pkg::running);
      end
   end

   // Bus opens out of reset, and only after a cycle with calib_done
   a_en_in_rst: assert property (@(posedge clk) disable iff (!rst_n)
      bus_en |-> !sys_rst && $past(calib_done));

endmodule

/* hw/axi_burst_slave.sv */
`timescale 1ns/1ns
`include "board_cfg.svh"

module axi_burst_slave (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    bus_en,
   input  board_pkg::axi_id_t      awid,
   input  board_pkg::axi_addr_t    awaddr,
   input  board_pkg::axi_len_t     awlen,
   input  board_pkg::axi_burst_t   awburst,
   input  logic                    awvalid,
   output logic                    awready,
   input  board_pkg::axi_data_t    wdata,
   input  board_pkg::axi_strb_t    wstrb,
   input  logic                    wlast,
   input  logic                    wvalid,
   output logic                    wready,
   output board_pkg::axi_id_t      bid,
   output board_pkg::axi_resp_t    bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  board_pkg::axi_id_t      arid,
   input  board_pkg::axi_addr_t    araddr,
   input  board_pkg::axi_len_t     arlen,
   input  board_pkg::axi_burst_t   arburst,
   input  logic                    arvalid,
   output logic                    arready,
   output board_pkg::axi_id_t      rid,
   output board_pkg::axi_data_t    rdata,
   output board_pkg::axi_resp_t    rresp,
   output logic                    rlast,
   output logic                    rvalid,
   input  logic                    rready,
   mem_req_if.master               mem
);

   typedef enum logic [1:0] {w_idle, w_data, w_resp} w_state_t;
   typedef enum logic {r_idle, r_busy} r_state_t;

   localparam board_pkg::axi_burst_t burst_fixed = 2'b00;
   localparam board_pkg::axi_addr_t  beat_bytes  = `BOARD_DATA_W / 8;
   localparam board_pkg::axi_addr_t  mem_bytes   = `BOARD_MEM_WORDS * (`BOARD_DATA_W / 8);
   localparam int                    word_lsb    = $clog2(`BOARD_DATA_W / 8);
   localparam int                    widx_w      = $bits(board_pkg::word_addr_t);

   w_state_t              w_state;
   board_pkg::axi_id_t    w_id;
   board_pkg::axi_addr_t  w_addr;
   board_pkg::axi_len_t   w_cnt;
   logic                  w_fixed;
   logic                  w_err;
   logic                  w_ok;
   logic                  w_beat;

   r_state_t              r_state;
   board_pkg::axi_id_t    r_id;
   board_pkg::axi_addr_t  r_addr;
   board_pkg::axi_len_t   r_cnt;
   logic                  r_fixed;
   logic                  r_ok;
   logic                  r_issue;
   logic                  r_err;

   assign w_ok    = (w_addr < mem_bytes);
   assign w_beat  = wvalid && wready;
   assign awready = bus_en && (w_state == w_idle);
   assign wready  = (w_state == w_data);
   assign bvalid  = (w_state == w_resp);
   assign bid     = w_id;
   assign bresp   = w_err ? board_pkg::resp_decerr : board_pkg::resp_okay;

   assign mem.wr_en   = w_beat && w_ok; // Out-of-range beats are dropped
   assign mem.wr_addr = w_addr[word_lsb +: widx_w];
   assign mem.wdata   = wdata;
   assign mem.wstrb   = wstrb;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_state <= w_idle;
      end else begin
         case (w_state)
            w_idle:  if (awvalid && awready) w_state <= w_data;
            w_data:  if (w_beat && w_cnt == '0) w_state <= w_resp;
            default: if (bready) w_state <= w_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         w_id    <= awid;
         w_addr  <= awaddr;
         w_cnt   <= awlen;
         w_fixed <= (awburst == burst_fixed);
         w_err   <= 1'b0;
      end else if (w_beat) begin
         w_err <= w_err | !w_ok;
         w_cnt <= w_cnt - 1'b1;
         if (!w_fixed)
            w_addr <= w_addr + beat_bytes;
      end
   end

   // Next beat goes out only if the output register frees up this cycle
   assign r_ok    = (r_addr < mem_bytes);
   assign r_issue = (r_state == r_busy) && (!rvalid || rready);
   assign arready = bus_en && (r_state == r_idle);

   assign mem.rd_en   = r_issue && r_ok;
   assign mem.rd_addr = r_addr[word_lsb +: widx_w];

   assign rresp = r_err ? board_pkg::resp_decerr : board_pkg::resp_okay;
   assign rdata = r_err ? '0 : mem.rdata; // Store output holds while stalled

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_state <= r_idle;
         rvalid  <= 1'b0;
      end else begin
         case (r_state)
            r_idle:  if (arvalid && arready) r_state <= r_busy;
            default: if (r_issue && r_cnt == '0) r_state <= r_idle;
         endcase
         if (r_issue)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (arvalid && arready) begin
         r_id    <= arid;
         r_addr  <= araddr;
         r_cnt   <= arlen;
         r_fixed <= (arburst == burst_fixed);
      end else if (r_issue) begin
         r_cnt <= r_cnt - 1'b1;
         if (!r_fixed)
            r_addr <= r_addr + beat_bytes;
      end
      if (r_issue) begin
         rid   <= r_id;  // Kept apart from r_id, a new AR may land under the last beat
         rlast <= (r_cnt == '0);
         r_err <= !r_ok;
      end
   end

   a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp));

   a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata) &&
                            $stable(rresp) && $stable(rlast));

   // Master's wlast must not end a burst early
   a_wlast: assert property (@(posedge clk) disable iff (!rst_n)
      w_beat && wlast |-> w_cnt == '0);

endmodule

/* hw/ddr_store.sv */
`timescale 1ns/1ns
`include "board_cfg.svh"

module ddr_store (
   input logic      clk,
   mem_req_if.store mem
);

   board_pkg::axi_data_t words [`BOARD_MEM_WORDS];

   // Byte lanes under strobe
   always_ff @(posedge clk) begin
      if (mem.wr_en) begin
         for (int i = 0; i < $bits(board_pkg::axi_strb_t); i++) begin
            if (mem.wstrb[i])
               words[mem.wr_addr][8*i +: 8] <= mem.wdata[8*i +: 8];
         end
      end
   end

   // Same-cycle write is not forwarded, the read sees the old word
   always_ff @(posedge clk) begin
      if (mem.rd_en)
         mem.rdata <= words[mem.rd_addr];
   end

endmodule

/* hw/arty_shell.sv */
`timescale 1ns/1ns
`include "board_cfg.svh"

module arty_shell (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       uart_txd_in,
   output logic                       uart_rxd_out,
   output logic                       sys_rst,
   output logic                       calib_done,
   input  board_pkg::axi_id_t         awid,
   input  board_pkg::axi_addr_t       awaddr,
   input  board_pkg::axi_len_t        awlen,
   input  board_pkg::axi_burst_t      awburst,
   input  logic                       awvalid,
   output logic                       awready,
   input  board_pkg::axi_data_t       wdata,
   input  board_pkg::axi_strb_t       wstrb,
   input  logic                       wlast,
   input  logic                       wvalid,
   output logic                       wready,
   output board_pkg::axi_id_t         bid,
   output board_pkg::axi_resp_t       bresp,
   output logic                       bvalid,
   input  logic                       bready,
   input  board_pkg::axi_id_t         arid,
   input  board_pkg::axi_addr_t       araddr,
   input  board_pkg::axi_len_t        arlen,
   input  board_pkg::axi_burst_t      arburst,
   input  logic                       arvalid,
   output logic                       arready,
   output board_pkg::axi_id_t         rid,
   output board_pkg::axi_data_t       rdata,
   output board_pkg::axi_resp_t       rresp,
   output logic                       rlast,
   output logic                       rvalid,
   input  logic                       rready,
   output logic [`BOARD_NUM_UART-1:0] uart_rx,
   input  logic [`BOARD_NUM_UART-1:0] uart_tx
);

   logic timer_start;
   logic timer_done;
   logic bus_en;

   mem_req_if u_mem_if ();

   // Board UART lane 0 straight through
   assign uart_rx[0]   = uart_txd_in;
   assign uart_rxd_out = uart_tx[0];

   reset_seq u_reset_seq (
      .clk         (clk),
      .rst_n       (rst_n),
      .timer_done  (timer_done),
      .timer_start (timer_start),
      .sys_rst     (sys_rst),
      .calib_done  (calib_done),
      .bus_en      (bus_en)
   );

   calib_timer u_calib_timer (
      .clk   (clk),
      .rst_n (rst_n),
      .start (timer_start),
      .done  (timer_done)
   );

   axi_burst_slave u_axi_burst_slave (
      .clk     (clk),     .rst_n   (rst_n),   .bus_en  (bus_en),
      .awid    (awid),    .awaddr  (awaddr),  .awlen   (awlen),
      .awburst (awburst), .awvalid (awvalid), .awready (awready),
      .wdata   (wdata),   .wstrb   (wstrb),   .wlast   (wlast),
      .wvalid  (wvalid),  .wready  (wready),
      .bid     (bid),     .bresp   (bresp),   .bvalid  (bvalid),  .bready (bready),
      .arid    (arid),    .araddr  (araddr),  .arlen   (arlen),
      .arburst (arburst), .arvalid (arvalid), .arready (arready),
      .rid     (rid),     .rdata   (rdata),   .rresp   (rresp),
      .rlast   (rlast),   .rvalid  (rvalid),  .rready  (rready),
      .mem     (u_mem_if.master)
   );

   ddr_store u_ddr_store (
      .clk (clk),
      .mem (u_mem_if.store)
   );

endmodule

/* tests/tb_arty_shell.sv */
`timescale 1ns/1ns
`include "board_cfg.svh"

module tb_arty_shell;

   localparam int mem_bytes   = `BOARD_MEM_WORDS * 4;
   // Prefill, 30 writes and reads, FIXED, back-pressure, concurrent, out of range
   localparam int total_beats = 128 + 2 * 30 * 8 + 4 + 3 + 8 + 3 * 8 + 1 + 2 + 1;
   localparam int cycle_limit = 60 + 20 * total_beats + 200;

   logic                          clk;
   logic                          rst_n;
   logic                          uart_txd_in;
   logic                          uart_rxd_out;
   logic                          sys_rst;
   logic                          calib_done;
   board_pkg::axi_id_t            awid;
   board_pkg::axi_addr_t          awaddr;
   board_pkg::axi_len_t           awlen;
   board_pkg::axi_burst_t         awburst;
   logic                          awvalid;
   logic                          awready;
   board_pkg::axi_data_t          wdata;
   board_pkg::axi_strb_t          wstrb;
   logic                          wlast;
   logic                          wvalid;
   logic                          wready;
   board_pkg::axi_id_t            bid;
   board_pkg::axi_resp_t          bresp;
   logic                          bvalid;
   logic                          bready;
   board_pkg::axi_id_t            arid;
   board_pkg::axi_addr_t          araddr;
   board_pkg::axi_len_t           arlen;
   board_pkg::axi_burst_t         arburst;
   logic                          arvalid;
   logic                          arready;
   board_pkg::axi_id_t            rid;
   board_pkg::axi_data_t          rdata;
   board_pkg::axi_resp_t          rresp;
   logic                          rlast;
   logic                          rvalid;
   logic                          rready;
   logic [`BOARD_NUM_UART-1:0]    uart_rx;
   logic [`BOARD_NUM_UART-1:0]    uart_tx;

   logic [31:0] model [`BOARD_MEM_WORDS]; // Unwritten words stay X, as in the store
   integer      seed;
   int          errors;
   int          tests_run;
   int          tests_passed;
   int          cycles;

   arty_shell u_dut (.*);

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, a handshake never completed", cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic tick();
      @(posedge clk);
      #10;
   endtask

   task automatic check_val(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Mismatch %s actual=%h expected=%h", name, actual, expected);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         tests_passed++;
         $display("PASS %s", name);
      end else begin
         $display("FAIL %s", name);
      end
   endtask

   task automatic write_burst(input logic [3:0] id, input logic [27:0] addr,
                              input logic [7:0] len, input logic [1:0] burst,
                              input logic rand_strb);
      logic [27:0] cur;
      logic [31:0] data;
      logic [3:0]  strb;
      logic        err;
      int          i;
      int          b;
      cur = addr;
      err = 1'b0;
      data = '0;
      awid = id;
      awaddr = addr;
      awlen = len;
      awburst = burst;
      awvalid = 1'b1;
      while (!awready)
         tick();
      tick();
      awvalid = 1'b0;
      for (i = 0; i <= len; i++) begin
         data = $random(seed);
         strb = rand_strb ? 4'($random(seed)) : 4'hf;
         wdata = data;
         wstrb = strb;
         wlast = (i == len);
         wvalid = 1'b1;
         while (!wready)
            tick();
         tick();
         if (cur < mem_bytes) begin
            for (b = 0; b < 4; b++)
               if (strb[b]) model[cur[11:2]][8*b +: 8] = data[8*b +: 8];
         end else begin
            err = 1'b1; // Beat dropped by the slave
         end
         if (burst != 2'b00)
            cur = cur + 28'd4;
      end
      wvalid = 1'b0;
      wlast = 1'b0;
      bready = 1'b1;
      while (!bvalid)
         tick();
      check_val("bid", bid, id);
      check_val("bresp", bresp, err ? 32'd3 : 32'd0);
      tick();
      bready = 1'b0;
   endtask

   task automatic read_burst(input logic [3:0] id, input logic [27:0] addr,
                             input logic [7:0] len, input logic [1:0] burst,
                             input logic stall);
      logic [27:0] cur;
      logic [31:0] exp_data;
      logic [31:0] hold_data;
      logic [3:0]  hold_id;
      logic [1:0]  hold_resp;
      logic        hold_last;
      logic        held;
      int          beat;
      cur = addr;
      beat = 0;
      held = 1'b0;
      arid = id;
      araddr = addr;
      arlen = len;
      arburst = burst;
      arvalid = 1'b1;
      while (!arready)
         tick();
      tick();
      arvalid = 1'b0;
      while (beat <= len) begin
         rready = stall ? 1'($random(seed)) : 1'b1;
         if (held) begin // Stalled beat must not change
            check_val("rvalid", rvalid, 1);
            check_val("rdata", rdata, hold_data);
            check_val("rid", rid, hold_id);
            check_val("rresp", rresp, hold_resp);
            check_val("rlast", rlast, hold_last);
         end
         held = 1'b0;
         if (rvalid && rready) begin
            exp_data = (cur < mem_bytes) ? model[cur[11:2]] : 32'd0;
            check_val("rdata", rdata, exp_data);
            check_val("rid", rid, id);
            check_val("rresp", rresp, (cur < mem_bytes) ? 32'd0 : 32'd3);
            check_val("rlast", rlast, beat == len);
            beat++;
            if (burst != 2'b00)
               cur = cur + 28'd4;
         end else if (rvalid) begin
            held = 1'b1;
            hold_data = rdata;
            hold_id = rid;
            hold_resp = rresp;
            hold_last = rlast;
         end
         tick();
      end
      rready = 1'b0;
      check_val("rvalid", rvalid, 0); // No extra beat after rlast
   endtask

   initial begin
      logic [27:0] w_addr [30];
      logic [7:0]  w_len [30];
      logic [31:0] start;
      int          n;
      int          errs;
      int          k;
      clk = 1'b0;
      rst_n = 1'b0;
      uart_txd_in = 1'b0;
      uart_tx = '0;
      awid = '0;
      awaddr = '0;
      awlen = '0;
      awburst = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wlast = 1'b0;
      wvalid = 1'b0;
      bready = 1'b0;
      arid = '0;
      araddr = '0;
      arlen = '0;
      arburst = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      seed = 75;
      errors = 0;
      tests_run = 0;
      tests_passed = 0;
      cycles = 0;

      // 1. Reset and calibration window
      errs = errors;
      repeat (3) begin
         tick();
         check_val("sys_rst", sys_rst, 1);
         check_val("calib_done", calib_done, 0);
         check_val("awready", awready, 0);
         check_val("wready", wready, 0);
         check_val("arready", arready, 0);
         check_val("bvalid", bvalid, 0);
         check_val("rvalid", rvalid, 0);
      end
      rst_n = 1'b1;
      n = 0;
      while (sys_rst && n < 100) begin
         tick();
         n++;
         if (sys_rst) begin
            if (n < `BOARD_CALIB_CYCLES + 1)
               check_val("calib_done", calib_done, 0);
            check_val("awready", awready, 0);
            check_val("wready", wready, 0);
            check_val("arready", arready, 0);
            check_val("bvalid", bvalid, 0);
            check_val("rvalid", rvalid, 0);
         end
      end
      check_val("sys_rst_cycles", n, `BOARD_CALIB_CYCLES + 2);
      check_val("calib_done", calib_done, 1);
      end_test("reset and calibration", errs);

      // 2. Prefill a 128-word window, then random INCR writes and read-back
      errs = errors;
      for (k = 0; k < 16; k++)
         write_burst(4'(k), 28'(k * 32), 8'd7, 2'b01, 1'b0);
      for (k = 0; k < 30; k++) begin
         start = $random(seed) & 32'h7f;
         if (start > 120)
            start = start - 8;
         w_addr[k] = 28'(start * 4);
         w_len[k] = 8'($random(seed) & 32'h7);
         write_burst(4'($random(seed)), w_addr[k], w_len[k], 2'b01, 1'b1);
      end
      for (k = 0; k < 30; k++)
         read_burst(4'($random(seed)), w_addr[k], w_len[k], 2'b01, 1'b0);
      end_test("random INCR bursts", errs);

      // 3. FIXED bursts keep the address
      errs = errors;
      write_burst(4'd6, 28'd1200, 8'd3, 2'b00, 1'b0);
      read_burst(4'd7, 28'd1200, 8'd2, 2'b00, 1'b0);
      end_test("FIXED bursts", errs);

      // 4. Read with random rready
      errs = errors;
      read_burst(4'd2, 28'd64, 8'd7, 2'b01, 1'b1);
      end_test("read back-pressure", errs);

      // 5. Write and read in flight together, then out-of-range access
      errs = errors;
      fork
         write_burst(4'd5, 28'h400, 8'd7, 2'b01, 1'b0);
         read_burst(4'd9, 28'h000, 8'd7, 2'b01, 1'b0);
      join
      read_burst(4'd10, 28'h400, 8'd7, 2'b01, 1'b0);
      write_burst(4'd3, 28'd4096, 8'd0, 2'b01, 1'b0);
      read_burst(4'd4, 28'd4100, 8'd1, 2'b01, 1'b0);
      read_burst(4'd11, 28'd0, 8'd0, 2'b01, 1'b0); // Aliased word untouched
      end_test("concurrent and out of range", errs);

      // 6. UART lane 0 wires
      errs = errors;
      repeat (16) begin
         uart_tx[0] = 1'($random(seed));
         uart_txd_in = 1'($random(seed));
         #1;
         check_val("uart_rxd_out", uart_rxd_out, uart_tx[0]);
         check_val("uart_rx", uart_rx[0], uart_txd_in);
         tick();
      end
      end_test("UART pass-through", errs);

      $display("Tests passed %0d of %0d, mismatches %0d", tests_passed, tests_run, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+hw
hw/board_pkg.sv
hw/mem_req_if.sv
hw/calib_timer.sv
hw/reset_seq.sv
hw/axi_burst_slave.sv
hw/ddr_store.sv
hw/arty_shell.sv
tests/tb_arty_shell.sv

/* Bender.yml */
package:
  name: arty_shell

sources:
  - include_dirs:
      - hw
    files:
      - hw/board_pkg.sv
      - hw/mem_req_if.sv
      - hw/calib_timer.sv
      - hw/reset_seq.sv
      - hw/axi_burst_slave.sv
      - hw/ddr_store.sv
      - hw/arty_shell.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_arty_shell.sv
